/* hw/shm_cfg.svh */
/*
 * build-time sizes for the shared-memory block
 * include wherever a width or the register window bit is needed
 */
`ifndef SHM_CFG_SVH
`define SHM_CFG_SVH

// width of one shared byte
`define SHM_DW 8

// ram word address width, 1024 words
`define SHM_AW 10

// cpu bus address width
// the extra top bit opens the register window
`define SHM_BUS_AW 11

// bus address bit that selects the register window over ram
`define SHM_WIN_BIT (`SHM_BUS_AW-1)

`endif

/* hw/shm_pkg.sv */
/*
 * types shared by the shared-memory block
 * reference them as shm_pkg::name
 */
package shm_pkg;

`include "shm_cfg.svh"

    // one shared data byte
    typedef logic [`SHM_DW-1:0] data_t;

    // word address into the dual-port ram
    typedef logic [`SHM_AW-1:0] ram_addr_t;

    // full cpu bus address, top bit is the window select
    typedef logic [`SHM_BUS_AW-1:0] bus_addr_t;

    // register index in the window
    // 0 is the doorbell, 1 is the semaphore
    typedef logic reg_sel_t;

    // who holds the hardware semaphore
    typedef enum logic [1:0] {
        SEM_FREE,
        SEM_MAIN,
        SEM_SND
    } sem_state_e;

endpackage

/* hw/shm_dual_ram.sv */
/*
 * generic true dual-port ram on one clock, read-first on each port
 * contents start at zero in simulation, there is no reset
 */
`timescale 1ns/1ps

module shm_dual_ram #(
    parameter int dw = 8,
    parameter int aw = 10
) (
    input  logic          clk0,
    // port 0
    input  logic [aw-1:0] addr0,
    input  logic [dw-1:0] data0,
    input  logic          we0,
    output logic [dw-1:0] q0,
    // port 1
    input  logic [aw-1:0] addr1,
    input  logic [dw-1:0] data1,
    input  logic          we1,
    output logic [dw-1:0] q1
);

    localparam int depth = 2**aw;

    logic [dw-1:0] mem [0:depth-1];

    // zero fill so simulation starts from known contents
    initial begin
        for (int i = 0; i < depth; i++) begin
            mem[i] = '0;
        end
    end

    // port 0
    // the read is sampled before the write of the same edge lands
    always @(posedge clk0) begin
        q0 <= mem[addr0];
        if (we0) begin
            mem[addr0] <= data0;
        end
    end

    // port 1, same read-first behaviour
    // a write from port 0 on this edge is not seen here until the next read
    always @(posedge clk0) begin
        q1 <= mem[addr1];
        if (we1) begin
            mem[addr1] <= data1;
        end
    end

endmodule

/* hw/shm_bus_port.sv */
/*
 * one cpu bus port: splits requests between ram and the register window
 * read data comes back two edges after the request with a one-cycle valid
 */
`timescale 1ns/1ps

`include "shm_cfg.svh"

module shm_bus_port (
    input  logic                clk0,
    input  logic                rst_n,
    // cpu side
    input  logic                cs,
    input  logic                we,
    input  shm_pkg::bus_addr_t  addr,
    input  shm_pkg::data_t      wdata,
    output shm_pkg::data_t      rd_data,
    output logic                rd_valid,
    // ram side
    output shm_pkg::ram_addr_t  ram_addr,
    output logic                ram_we,
    output shm_pkg::data_t      ram_wdata,
    input  shm_pkg::data_t      ram_q,
    // register window side
    output logic                reg_rd,
    output logic                reg_wr,
    output shm_pkg::reg_sel_t   reg_sel,
    output shm_pkg::data_t      reg_wdata,
    input  shm_pkg::data_t      reg_rdata
);

    // high when the request targets the register window
    logic win;
    // a read was taken on the last edge
    logic rd_pend;
    // that read went to the register window
    logic rd_pend_reg;

    assign win = addr[`SHM_WIN_BIT];

    // ram strobes, low address bits go straight through
    assign ram_addr  = addr[`SHM_AW-1:0];
    assign ram_we    = cs & we & ~win;
    assign ram_wdata = wdata;

    // register strobes, bit 0 picks doorbell or semaphore
    assign reg_rd    = cs & ~we & win;
    assign reg_wr    = cs & we & win;
    assign reg_sel   = addr[0];
    assign reg_wdata = wdata;

    // read tracking
    // stage one notes the read, stage two raises rd_valid
    always_ff @(posedge clk0) begin
        if (!rst_n) begin
            rd_pend  <= 1'b0;
            rd_valid <= 1'b0;
        end else begin
            rd_pend  <= cs & ~we;
            rd_valid <= rd_pend;
        end
    end

    // source select follows the request by one edge
    always_ff @(posedge clk0) begin
        rd_pend_reg <= win;
    end

    // ram_q and reg_rdata are both registered at the request edge,
    // so they are stable here and one of them is captured
    always_ff @(posedge clk0) begin
        if (rd_pend) begin
            rd_data <= rd_pend_reg ? reg_rdata : ram_q;
        end
    end

endmodule

/* hw/shm_mailbox.sv */
/*
 * doorbell latches, interrupt flags and the test-and-set semaphore
 * shared by the main and sound cpu; read data is registered
 */
`timescale 1ns/1ps

module shm_mailbox (
    input  logic               clk0,
    input  logic               rst_n,
    // main cpu register window
    input  logic               main_reg_rd,
    input  logic               main_reg_wr,
    input  shm_pkg::reg_sel_t  main_reg_sel,
    input  shm_pkg::data_t     main_reg_wdata,
    output shm_pkg::data_t     main_reg_rdata,
    // sound cpu register window
    input  logic               snd_reg_rd,
    input  logic               snd_reg_wr,
    input  shm_pkg::reg_sel_t  snd_reg_sel,
    input  shm_pkg::data_t     snd_reg_wdata,
    output shm_pkg::data_t     snd_reg_rdata,
    // interrupt levels towards each cpu
    output logic               main_irq,
    output logic               snd_irq
);

    // message waiting for each side
    shm_pkg::data_t msg_to_main;
    shm_pkg::data_t msg_to_snd;

    // doorbell strobes, register 0
    logic main_bell_wr;
    logic main_bell_rd;
    logic snd_bell_wr;
    logic snd_bell_rd;

    // semaphore strobes, register 1
    logic main_acq;
    logic main_rel;
    logic snd_acq;
    logic snd_rel;

    // lock owner now and after this edge
    shm_pkg::sem_state_e sem_q;
    shm_pkg::sem_state_e sem_d;

    // grant bits as seen by each reader
    logic main_grant;
    logic snd_grant;

    assign main_bell_wr = main_reg_wr & ~main_reg_sel;
    assign main_bell_rd = main_reg_rd & ~main_reg_sel;
    assign snd_bell_wr  = snd_reg_wr & ~snd_reg_sel;
    assign snd_bell_rd  = snd_reg_rd & ~snd_reg_sel;

    assign main_acq = main_reg_rd & main_reg_sel;
    assign main_rel = main_reg_wr & main_reg_sel;
    assign snd_acq  = snd_reg_rd & snd_reg_sel;
    assign snd_rel  = snd_reg_wr & snd_reg_sel;

    // message latches
    // a write by one side is the message for the other
    always_ff @(posedge clk0) begin
        if (!rst_n) begin
            msg_to_main <= '0;
            msg_to_snd  <= '0;
        end else begin
            if (main_bell_wr) begin
                msg_to_snd <= main_reg_wdata;
            end
            if (snd_bell_wr) begin
                msg_to_main <= snd_reg_wdata;
            end
        end
    end

    // irq flags
    // set wins over the owner's clearing read in the same cycle
    always_ff @(posedge clk0) begin
        if (!rst_n) begin
            main_irq <= 1'b0;
            snd_irq  <= 1'b0;
        end else begin
            if (snd_bell_wr) begin
                main_irq <= 1'b1;
            end else if (main_bell_rd) begin
                main_irq <= 1'b0;
            end
            if (main_bell_wr) begin
                snd_irq <= 1'b1;
            end else if (snd_bell_rd) begin
                snd_irq <= 1'b0;
            end
        end
    end

    // semaphore fsm
    // a free lock goes to main first when both sides ask together
    // releases from the side that does not own the lock are ignored
    always_comb begin
        sem_d = sem_q;
        case (sem_q)
            shm_pkg::SEM_FREE: begin
                if (main_acq) begin
                    sem_d = shm_pkg::SEM_MAIN;
                end else if (snd_acq) begin
                    sem_d = shm_pkg::SEM_SND;
                end
            end
            shm_pkg::SEM_MAIN: begin
                if (main_rel) begin
                    sem_d = shm_pkg::SEM_FREE;
                end
            end
            shm_pkg::SEM_SND: begin
                if (snd_rel) begin
                    sem_d = shm_pkg::SEM_FREE;
                end
            end
            default: begin
                sem_d = shm_pkg::SEM_FREE;
            end
        endcase
    end

    always_ff @(posedge clk0) begin
        if (!rst_n) begin
            sem_q <= shm_pkg::SEM_FREE;
        end else begin
            sem_q <= sem_d;
        end
    end

    // test-and-set answer is ownership after this edge
    assign main_grant = (sem_d == shm_pkg::SEM_MAIN);
    assign snd_grant  = (sem_d == shm_pkg::SEM_SND);

    // registered read data, lines up with the ram output
    // doorbell reads return the latch before any same-cycle write
    always_ff @(posedge clk0) begin
        if (main_reg_rd) begin
            main_reg_rdata <= main_reg_sel ? shm_pkg::data_t'(main_grant) : msg_to_main;
        end
        if (snd_reg_rd) begin
            snd_reg_rdata <= snd_reg_sel ? shm_pkg::data_t'(snd_grant) : msg_to_snd;
        end
    end

endmodule

/* hw/shm_top.sv */
/*
 * shared-memory block between the main and sound cpu
 * two bus ports share one dual-port ram and one mailbox, all on clk0
 */
`timescale 1ns/1ps

`include "shm_cfg.svh"

module shm_top (
    input  logic                clk0,
    input  logic                rst_n,
    // main cpu
    input  logic                main_cs,
    input  logic                main_we,
    input  shm_pkg::bus_addr_t  main_addr,
    input  shm_pkg::data_t      main_wdata,
    output shm_pkg::data_t      main_rd_data,
    output logic                main_rd_valid,
    output logic                main_irq,
    // sound cpu
    input  logic                snd_cs,
    input  logic                snd_we,
    input  shm_pkg::bus_addr_t  snd_addr,
    input  shm_pkg::data_t      snd_wdata,
    output shm_pkg::data_t      snd_rd_data,
    output logic                snd_rd_valid,
    output logic                snd_irq
);

    // main port towards ram port 0 and the mailbox
    shm_pkg::ram_addr_t main_ram_addr;
    logic               main_ram_we;
    shm_pkg::data_t     main_ram_wdata;
    shm_pkg::data_t     main_ram_q;
    logic               main_reg_rd;
    logic               main_reg_wr;
    shm_pkg::reg_sel_t  main_reg_sel;
    shm_pkg::data_t     main_reg_wdata;
    shm_pkg::data_t     main_reg_rdata;

    // sound port towards ram port 1 and the mailbox
    shm_pkg::ram_addr_t snd_ram_addr;
    logic               snd_ram_we;
    shm_pkg::data_t     snd_ram_wdata;
    shm_pkg::data_t     snd_ram_q;
    logic               snd_reg_rd;
    logic               snd_reg_wr;
    shm_pkg::reg_sel_t  snd_reg_sel;
    shm_pkg::data_t     snd_reg_wdata;
    shm_pkg::data_t     snd_reg_rdata;

    shm_bus_port u_main_port (
        .clk0      (clk0),
        .rst_n     (rst_n),
        .cs        (main_cs),
        .we        (main_we),
        .addr      (main_addr),
        .wdata     (main_wdata),
        .rd_data   (main_rd_data),
        .rd_valid  (main_rd_valid),
        .ram_addr  (main_ram_addr),
        .ram_we    (main_ram_we),
        .ram_wdata (main_ram_wdata),
        .ram_q     (main_ram_q),
        .reg_rd    (main_reg_rd),
        .reg_wr    (main_reg_wr),
        .reg_sel   (main_reg_sel),
        .reg_wdata (main_reg_wdata),
        .reg_rdata (main_reg_rdata)
    );

    shm_bus_port u_snd_port (
        .clk0      (clk0),
        .rst_n     (rst_n),
        .cs        (snd_cs),
        .we        (snd_we),
        .addr      (snd_addr),
        .wdata     (snd_wdata),
        .rd_data   (snd_rd_data),
        .rd_valid  (snd_rd_valid),
        .ram_addr  (snd_ram_addr),
        .ram_we    (snd_ram_we),
        .ram_wdata (snd_ram_wdata),
        .ram_q     (snd_ram_q),
        .reg_rd    (snd_reg_rd),
        .reg_wr    (snd_reg_wr),
        .reg_sel   (snd_reg_sel),
        .reg_wdata (snd_reg_wdata),
        .reg_rdata (snd_reg_rdata)
    );

    // port 0 is main, port 1 is sound
    shm_dual_ram #(
        .dw (`SHM_DW),
        .aw (`SHM_AW)
    ) u_ram (
        .clk0  (clk0),
        .addr0 (main_ram_addr),
        .data0 (main_ram_wdata),
        .we0   (main_ram_we),
        .q0    (main_ram_q),
        .addr1 (snd_ram_addr),
        .data1 (snd_ram_wdata),
        .we1   (snd_ram_we),
        .q1    (snd_ram_q)
    );

    shm_mailbox u_mailbox (
        .clk0           (clk0),
        .rst_n          (rst_n),
        .main_reg_rd    (main_reg_rd),
        .main_reg_wr    (main_reg_wr),
        .main_reg_sel   (main_reg_sel),
        .main_reg_wdata (main_reg_wdata),
        .main_reg_rdata (main_reg_rdata),
        .snd_reg_rd     (snd_reg_rd),
        .snd_reg_wr     (snd_reg_wr),
        .snd_reg_sel    (snd_reg_sel),
        .snd_reg_wdata  (snd_reg_wdata),
        .snd_reg_rdata  (snd_reg_rdata),
        .main_irq       (main_irq),
        .snd_irq        (snd_irq)
    );

endmodule

/* verification/tb_clock_gen.sv */
/*
 * testbench clock and reset source
 * 8 ns clk0, rst_n held low for the first 8 rising edges
 */
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int half_period  = 4,
    parameter int reset_cycles = 8
) (
    output logic clk0,
    output logic rst_n
);

    // free running clock, starts low
    initial begin
        clk0 = 1'b0;
        forever #(half_period) clk0 = ~clk0;
    end

    // release on a falling edge, away from the sampling edge
    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk0);
        @(negedge clk0);
        rst_n = 1'b1;
    end

endmodule

/* verification/tb_shm_top.sv */
/*
 * testbench for the shared-memory block
 * random traffic from an lfsr on both cpu ports, checked against a behavioural model
 */
`timescale 1ns/1ps

`include "shm_cfg.svh"

module tb_shm_top;

    // test lengths in cycles
    localparam int n_single    = 250;
    localparam int n_cross     = 300;
    localparam int n_bell_dir  = 16;
    localparam int n_bell_rand = 120;
    localparam int n_sem       = 250;
    localparam int total_cycles = 9 + 4 + 2 * (n_single + 3) + (n_cross + 3)
                                + (n_bell_dir * 5 + n_bell_rand + 3) + (n_sem + 5);

    // register window addresses
    localparam shm_pkg::bus_addr_t bell_addr = 1 << (`SHM_BUS_AW - 1);
    localparam shm_pkg::bus_addr_t sem_addr  = bell_addr | 1;

    logic               clk0;
    logic               rst_n;
    logic               main_cs;
    logic               main_we;
    shm_pkg::bus_addr_t main_addr;
    shm_pkg::data_t     main_wdata;
    shm_pkg::data_t     main_rd_data;
    logic               main_rd_valid;
    logic               main_irq;
    logic               snd_cs;
    logic               snd_we;
    shm_pkg::bus_addr_t snd_addr;
    shm_pkg::data_t     snd_wdata;
    shm_pkg::data_t     snd_rd_data;
    logic               snd_rd_valid;
    logic               snd_irq;

    // reference model state
    shm_pkg::data_t      model_mem [0:(1 << `SHM_AW) - 1];
    shm_pkg::data_t      msg_to_main;
    shm_pkg::data_t      msg_to_snd;
    logic                exp_main_irq;
    logic                exp_snd_irq;
    shm_pkg::sem_state_e owner;
    // expected read results and the cycle each one is due on
    shm_pkg::data_t      main_exp_data [$];
    int                  main_exp_due [$];
    shm_pkg::data_t      snd_exp_data [$];
    int                  snd_exp_due [$];

    int          cyc;
    int          errors;
    int          reads_checked;
    logic [31:0] lfsr;

    tb_clock_gen u_clock_gen (
        .clk0  (clk0),
        .rst_n (rst_n)
    );

    shm_top u_shm_top (
        .clk0          (clk0),
        .rst_n         (rst_n),
        .main_cs       (main_cs),
        .main_we       (main_we),
        .main_addr     (main_addr),
        .main_wdata    (main_wdata),
        .main_rd_data  (main_rd_data),
        .main_rd_valid (main_rd_valid),
        .main_irq      (main_irq),
        .snd_cs        (snd_cs),
        .snd_we        (snd_we),
        .snd_addr      (snd_addr),
        .snd_wdata     (snd_wdata),
        .snd_rd_data   (snd_rd_data),
        .snd_rd_valid  (snd_rd_valid),
        .snd_irq       (snd_irq)
    );

    // fibonacci lfsr, taps 32 22 2 1, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    // ram address, half the time squeezed into a few words so that hits happen
    function automatic shm_pkg::bus_addr_t random_ram_addr(input int narrow_bits);
        logic [31:0] r;
        if (rand_bits(1) == 1) begin
            r = rand_bits(narrow_bits);
        end else begin
            r = rand_bits(`SHM_AW);
        end
        return shm_pkg::bus_addr_t'(r[`SHM_AW-1:0]);
    endfunction

    task automatic pop_expected(input int side);
        if (side == 0) begin
            void'(main_exp_data.pop_front());
            void'(main_exp_due.pop_front());
        end else begin
            void'(snd_exp_data.pop_front());
            void'(snd_exp_due.pop_front());
        end
    endtask

    // compare one side's read result with the head of its queue
    task automatic check_read(input int side, input logic valid, input shm_pkg::data_t data);
        string          side_name;
        int             pending;
        int             due;
        shm_pkg::data_t exp;
        side_name = (side == 0) ? "main" : "snd";
        pending   = (side == 0) ? main_exp_due.size() : snd_exp_due.size();
        due = -1;
        exp = '0;
        if (pending > 0) begin
            due = (side == 0) ? main_exp_due[0] : snd_exp_due[0];
            exp = (side == 0) ? main_exp_data[0] : snd_exp_data[0];
        end
        if (valid === 1'b1) begin
            assert (pending > 0) else begin
                $display("%0t ns: %s_rd_valid pulsed with no read outstanding", $time, side_name);
                errors++;
            end
            if (pending > 0) begin
                assert (due == cyc) else begin
                    $display("%0t ns: %s read result came on cycle %0d instead of cycle %0d",
                             $time, side_name, cyc, due);
                    errors++;
                end
                assert (data === exp) else begin
                    $display("CHECK FAILED at %0t ns: %s_rd_data expected %02h got %02h",
                             $time, side_name, exp, data);
                    errors++;
                end
                reads_checked++;
                pop_expected(side);
            end
        end else begin
            // a read that is due now and got no valid is dropped after reporting
            assert (pending == 0 || due > cyc) else begin
                $display("%0t ns: %s read due on cycle %0d never raised rd_valid",
                         $time, side_name, due);
                errors++;
                pop_expected(side);
            end
        end
    endtask

    task automatic check_irqs();
        assert (main_irq === exp_main_irq) else begin
            $display("CHECK FAILED at %0t ns: main_irq expected %0b got %0b",
                     $time, exp_main_irq, main_irq);
            errors++;
        end
        assert (snd_irq === exp_snd_irq) else begin
            $display("CHECK FAILED at %0t ns: snd_irq expected %0b got %0b",
                     $time, exp_snd_irq, snd_irq);
            errors++;
        end
    endtask

    // advance the model by one clock edge carrying both requests
    task automatic model_apply(input logic mc, input logic mw, input shm_pkg::bus_addr_t ma,
                               input shm_pkg::data_t md, input logic sc, input logic sw,
                               input shm_pkg::bus_addr_t sa, input shm_pkg::data_t sd);
        logic                m_rd;
        logic                s_rd;
        logic                m_win;
        logic                s_win;
        shm_pkg::sem_state_e nxt;
        shm_pkg::data_t      m_val;
        shm_pkg::data_t      s_val;
        m_rd  = mc & ~mw;
        s_rd  = sc & ~sw;
        m_win = ma[`SHM_BUS_AW-1];
        s_win = sa[`SHM_BUS_AW-1];
        // semaphore, tie on a free lock goes to main
        nxt = owner;
        if (owner == shm_pkg::SEM_FREE) begin
            if (m_rd && m_win && ma[0]) begin
                nxt = shm_pkg::SEM_MAIN;
            end else if (s_rd && s_win && sa[0]) begin
                nxt = shm_pkg::SEM_SND;
            end
        end else if (owner == shm_pkg::SEM_MAIN && mc && mw && m_win && ma[0]) begin
            nxt = shm_pkg::SEM_FREE;
        end else if (owner == shm_pkg::SEM_SND && sc && sw && s_win && sa[0]) begin
            nxt = shm_pkg::SEM_FREE;
        end
        // read values come from the state before this edge's writes
        m_val = '0;
        s_val = '0;
        if (!m_win) begin
            m_val = model_mem[ma[`SHM_AW-1:0]];
        end else if (ma[0]) begin
            m_val[0] = (nxt == shm_pkg::SEM_MAIN);
        end else begin
            m_val = msg_to_main;
        end
        if (!s_win) begin
            s_val = model_mem[sa[`SHM_AW-1:0]];
        end else if (sa[0]) begin
            s_val[0] = (nxt == shm_pkg::SEM_SND);
        end else begin
            s_val = msg_to_snd;
        end
        if (m_rd) begin
            main_exp_data.push_back(m_val);
            main_exp_due.push_back(cyc + 2);
        end
        if (s_rd) begin
            snd_exp_data.push_back(s_val);
            snd_exp_due.push_back(cyc + 2);
        end
        // doorbells, a set beats the owner's clearing read
        if (sc && sw && s_win && !sa[0]) begin
            exp_main_irq = 1'b1;
            msg_to_main  = sd;
        end else if (m_rd && m_win && !ma[0]) begin
            exp_main_irq = 1'b0;
        end
        if (mc && mw && m_win && !ma[0]) begin
            exp_snd_irq = 1'b1;
            msg_to_snd  = md;
        end else if (s_rd && s_win && !sa[0]) begin
            exp_snd_irq = 1'b0;
        end
        if (mc && mw && !m_win) begin
            model_mem[ma[`SHM_AW-1:0]] = md;
        end
        if (sc && sw && !s_win) begin
            model_mem[sa[`SHM_AW-1:0]] = sd;
        end
        owner = nxt;
    endtask

    // one cycle: check outputs on the falling edge, then drive the next requests
    task automatic drive_cycle(input logic mc, input logic mw, input shm_pkg::bus_addr_t ma,
                               input shm_pkg::data_t md, input logic sc, input logic sw,
                               input shm_pkg::bus_addr_t sa, input shm_pkg::data_t sd);
        @(negedge clk0);
        cyc = cyc + 1;
        check_read(0, main_rd_valid, main_rd_data);
        check_read(1, snd_rd_valid, snd_rd_data);
        check_irqs();
        model_apply(mc, mw, ma, md, sc, sw, sa, sd);
        main_cs    = mc;
        main_we    = mw;
        main_addr  = ma;
        main_wdata = md;
        snd_cs     = sc;
        snd_we     = sw;
        snd_addr   = sa;
        snd_wdata  = sd;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) drive_cycle(1'b0, 1'b0, '0, '0, 1'b0, 1'b0, '0, '0);
    endtask

    // drain outstanding reads, then one line for the test
    task automatic finish_test(input int num, input string title, input int errs_before);
        idle_cycles(3);
        $display("test %0d %s: %0d errors", num, title, errors - errs_before);
    endtask

    // watchdog, twice the planned run time
    initial begin
        #(total_cycles * 8 * 2);
        $display("run timed out after %0d ns without reaching the end", total_cycles * 16);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        logic               mc;
        logic               mw;
        logic               sc;
        logic               sw;
        shm_pkg::bus_addr_t ma;
        shm_pkg::bus_addr_t sa;
        shm_pkg::data_t     md;
        shm_pkg::data_t     sd;
        int                 errs_before;

        main_cs = 1'b0;
        main_we = 1'b0;
        main_addr = '0;
        main_wdata = '0;
        snd_cs = 1'b0;
        snd_we = 1'b0;
        snd_addr = '0;
        snd_wdata = '0;
        lfsr = 32'h057d_77f3;
        cyc = 0;
        errors = 0;
        reads_checked = 0;
        // ram starts zeroed, reset clears latches, flags and lock
        for (int i = 0; i < (1 << `SHM_AW); i++) begin
            model_mem[i] = '0;
        end
        msg_to_main  = '0;
        msg_to_snd   = '0;
        exp_main_irq = 1'b0;
        exp_snd_irq  = 1'b0;
        owner        = shm_pkg::SEM_FREE;

        // test 1, outputs quiet through reset, then snd takes the free lock
        // flops are unknown until the first rising edge applies the reset
        errs_before = errors;
        @(posedge clk0);
        repeat (8) begin
            @(negedge clk0);
            assert (main_rd_valid === 1'b0) else begin
                $display("CHECK FAILED at %0t ns: main_rd_valid expected 0 got %b",
                         $time, main_rd_valid);
                errors++;
            end
            assert (snd_rd_valid === 1'b0) else begin
                $display("CHECK FAILED at %0t ns: snd_rd_valid expected 0 got %b",
                         $time, snd_rd_valid);
                errors++;
            end
            check_irqs();
        end
        drive_cycle(1'b0, 1'b0, '0, '0, 1'b1, 1'b0, sem_addr, '0);
        finish_test(1, "reset state", errs_before);

        // test 2, ram traffic on one side at a time
        errs_before = errors;
        repeat (n_single) begin
            mc = (rand_bits(2) != 0);
            mw = (rand_bits(1) == 1);
            ma = random_ram_addr(4);
            md = shm_pkg::data_t'(rand_bits(`SHM_DW));
            drive_cycle(mc, mw, ma, md, 1'b0, 1'b0, '0, '0);
        end
        repeat (n_single) begin
            sc = (rand_bits(2) != 0);
            sw = (rand_bits(1) == 1);
            sa = random_ram_addr(4);
            sd = shm_pkg::data_t'(rand_bits(`SHM_DW));
            drive_cycle(1'b0, 1'b0, '0, '0, sc, sw, sa, sd);
        end
        finish_test(2, "single port ram", errs_before);

        // test 3, both sides every cycle on a small address range
        errs_before = errors;
        repeat (n_cross) begin
            mw = (rand_bits(1) == 1);
            sw = (rand_bits(1) == 1);
            ma = random_ram_addr(5);
            sa = random_ram_addr(5);
            md = shm_pkg::data_t'(rand_bits(`SHM_DW));
            sd = shm_pkg::data_t'(rand_bits(`SHM_DW));
            // same-word writes from both sides are undefined
            if (mw && sw && ma == sa) begin
                sw = 1'b0;
            end
            drive_cycle(1'b1, mw, ma, md, 1'b1, sw, sa, sd);
        end
        finish_test(3, "cross port ram", errs_before);

        // test 4, doorbell ring then answer, followed by random bell traffic
        errs_before = errors;
        repeat (n_bell_dir) begin
            md = shm_pkg::data_t'(rand_bits(`SHM_DW));
            if (rand_bits(1) == 1) begin
                drive_cycle(1'b1, 1'b1, bell_addr, md, 1'b0, 1'b0, '0, '0);
                idle_cycles(1);
                drive_cycle(1'b0, 1'b0, '0, '0, 1'b1, 1'b0, bell_addr, '0);
            end else begin
                drive_cycle(1'b0, 1'b0, '0, '0, 1'b1, 1'b1, bell_addr, md);
                idle_cycles(1);
                drive_cycle(1'b1, 1'b0, bell_addr, '0, 1'b0, 1'b0, '0, '0);
            end
            idle_cycles(2);
        end
        repeat (n_bell_rand) begin
            mc = (rand_bits(1) == 1);
            mw = (rand_bits(1) == 1);
            sc = (rand_bits(1) == 1);
            sw = (rand_bits(1) == 1);
            md = shm_pkg::data_t'(rand_bits(`SHM_DW));
            sd = shm_pkg::data_t'(rand_bits(`SHM_DW));
            drive_cycle(mc, mw, bell_addr, md, sc, sw, bell_addr, sd);
        end
        finish_test(4, "doorbell", errs_before);

        // test 5, release from both, a tie on the free lock, then random contention
        errs_before = errors;
        drive_cycle(1'b1, 1'b1, sem_addr, '0, 1'b1, 1'b1, sem_addr, '0);
        drive_cycle(1'b1, 1'b0, sem_addr, '0, 1'b1, 1'b0, sem_addr, '0);
        repeat (n_sem) begin
            mc = (rand_bits(1) == 1);
            mw = (rand_bits(1) == 1);
            sc = (rand_bits(1) == 1);
            sw = (rand_bits(1) == 1);
            md = shm_pkg::data_t'(rand_bits(`SHM_DW));
            sd = shm_pkg::data_t'(rand_bits(`SHM_DW));
            drive_cycle(mc, mw, sem_addr, md, sc, sw, sem_addr, sd);
        end
        finish_test(5, "semaphore", errs_before);

        $display("summary: 5 tests, %0d reads checked, %0d errors", reads_checked, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* verilog.f */
+incdir+hw
hw/shm_pkg.sv
hw/shm_dual_ram.sv
hw/shm_bus_port.sv
hw/shm_mailbox.sv
hw/shm_top.sv
verification/tb_clock_gen.sv
verification/tb_shm_top.sv
